/* files.f */
common/bp_pkg.sv
src/bp_table.sv
btb/btb.sv
perceptron/perceptron.sv
src/perceptron_bp.sv
verification/perceptron_bp_sva.sv
verification/tb_perceptron_bp.sv

/* verification/tb_perceptron_bp.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_perceptron_bp import bp_pkg::*; ();

	localparam int CLK_PERIOD = 40;				// ns.
	localparam int MAX_CYCLES = 4000;			// Watchdog limit for the whole run.
	localparam logic [31:0] SEED = 32'h55f8_9317;

	logic               clk;
	logic               rst_n_i;
	logic [BP_PC_W-1:0] if2bp_pc_i;
	logic               if2bp_pc_vld_i;
	logic               fu2bp_br_cond_i;
	logic               fu2bp_br_taken_i;
	logic [BP_PC_W-1:0] fu2bp_br_pc_i;
	logic [BP_PC_W-1:0] fu2bp_br_target_i;
	logic               fu2bp_br_done_i;
	logic [BP_PC_W-1:0] btb_target_o;
	logic               bp_pred_o;

	// Reference model state.
	logic                 m_valid  [0:BTB_ENTRIES-1];
	logic [BTB_TAG_W-1:0] m_tag    [0:BTB_ENTRIES-1];
	logic                 m_cond   [0:BTB_ENTRIES-1];
	logic [BP_PC_W-1:0]   m_target [0:BTB_ENTRIES-1];
	int                   m_w      [0:PT_ROWS-1][0:PT_HIST_LEN];	// Index 0 is the bias.
	logic [PT_HIST_LEN-1:0] m_hist;		// Bit 0 holds the newest outcome.

	logic               exp_pred;		// Model prediction for this edge.
	logic [BP_PC_W-1:0] exp_target;		// Model target for this edge.
	logic               run_done = 1'b0;	// Stimulus finished.
	int                 error_cnt;

	perceptron_bp perceptron_bp_i (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.if2bp_pc_i        (if2bp_pc_i),
		.if2bp_pc_vld_i    (if2bp_pc_vld_i),
		.fu2bp_br_cond_i   (fu2bp_br_cond_i),
		.fu2bp_br_taken_i  (fu2bp_br_taken_i),
		.fu2bp_br_pc_i     (fu2bp_br_pc_i),
		.fu2bp_br_target_i (fu2bp_br_target_i),
		.fu2bp_br_done_i   (fu2bp_br_done_i),
		.btb_target_o      (btb_target_o),
		.bp_pred_o         (bp_pred_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;	// 40 ns period.
	end

	task automatic fail_now(input string msg);
		error_cnt++;
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic int btb_idx(input logic [BP_PC_W-1:0] pc);
		return int'(pc[BTB_IDX_W+1:2]);		// PC[7:2].
	endfunction

	function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [BP_PC_W-1:0] pc);
		return pc[BP_PC_W-1:BTB_IDX_W+2];
	endfunction

	function automatic int pt_row(input logic [BP_PC_W-1:0] pc);
		return int'(pc[PT_IDX_W+1:2]);		// PC[6:2].
	endfunction

	function automatic logic btb_hit(input logic [BP_PC_W-1:0] pc);
		return m_valid[btb_idx(pc)] && (m_tag[btb_idx(pc)] == btb_tag(pc));
	endfunction

	// Bias plus signed weights, sign chosen by the history bit.
	function automatic int model_sum(input int row);
		int y;
		y = m_w[row][0];
		for (int i = 0; i < PT_HIST_LEN; i++) begin
			y = m_hist[i] ? y + m_w[row][i+1] : y - m_w[row][i+1];
		end
		return y;
	endfunction

	function automatic int step_weight(input int w, input logic up);
		if (up) begin
			return (w < PT_WEIGHT_MAX) ? w + 1 : w;	// Hold at +127.
		end
		return (w > PT_WEIGHT_MIN) ? w - 1 : w;		// Hold at -128.
	endfunction

	function automatic logic model_pred(input logic [BP_PC_W-1:0] pc, input logic vld);
		if (!vld || !btb_hit(pc)) begin
			return 1'b0;				// Miss or no fetch.
		end
		if (!m_cond[btb_idx(pc)]) begin
			return 1'b1;				// Unconditional hit.
		end
		return model_sum(pt_row(pc)) >= 0;
	endfunction

	task automatic clear_model();
		for (int i = 0; i < BTB_ENTRIES; i++) begin
			m_valid[i]  = 1'b0;
			m_tag[i]    = '0;
			m_cond[i]   = 1'b0;
			m_target[i] = '0;
		end
		for (int r = 0; r < PT_ROWS; r++) begin
			for (int i = 0; i <= PT_HIST_LEN; i++) begin
				m_w[r][i] = 0;
			end
		end
		m_hist = '0;
	endtask

	task automatic train_model(input logic [BP_PC_W-1:0] pc, input logic cond,
			input logic taken, input logic [BP_PC_W-1:0] target);
		int   idx;
		int   row;
		int   y;
		logic train;
		idx = btb_idx(pc);
		if (taken) begin
			m_valid[idx]  = 1'b1;			// Allocate or refresh.
			m_tag[idx]    = btb_tag(pc);
			m_cond[idx]   = cond;
			m_target[idx] = target;
		end else if (btb_hit(pc)) begin
			m_valid[idx] = 1'b0;			// Evict own entry only.
		end
		if (cond) begin
			row   = pt_row(pc);
			y     = model_sum(row);
			train = ((y >= 0) != taken) || ((y <= PT_THETA) && (y >= -PT_THETA));
			if (train) begin
				m_w[row][0] = step_weight(m_w[row][0], taken);
				for (int i = 0; i < PT_HIST_LEN; i++) begin
					m_w[row][i+1] = step_weight(m_w[row][i+1], taken == m_hist[i]);
				end
			end
			m_hist = {m_hist[PT_HIST_LEN-2:0], taken};	// Old history used above.
		end
	endtask

	// Compare before the edge's updates land, then advance the model.
	always @(posedge clk) begin
		if (!rst_n_i) begin
			clear_model();
		end else begin
			exp_pred   = model_pred(if2bp_pc_i, if2bp_pc_vld_i);
			exp_target = btb_hit(if2bp_pc_i) ? m_target[btb_idx(if2bp_pc_i)] : '0;
			assert (bp_pred_o === exp_pred)
				else fail_now($sformatf("error: bp_pred_o expected %h actual %h",
					exp_pred, bp_pred_o));
			assert (btb_target_o === exp_target)
				else fail_now($sformatf("error: btb_target_o expected %h actual %h",
					exp_target, btb_target_o));
			if (fu2bp_br_done_i) begin
				train_model(fu2bp_br_pc_i, fu2bp_br_cond_i, fu2bp_br_taken_i,
					fu2bp_br_target_i);
			end
		end
	end

	// Concurrent assertion failures in the bound checker also end the run.
	always @(negedge clk) begin
		if (perceptron_bp_i.perceptron_bp_sva_i.fail_cnt != 0) begin
			fail_now("a concurrent assertion on perceptron_bp failed");
		end
	end

	task automatic drive_cycle(input logic [BP_PC_W-1:0] lk_pc, input logic lk_vld,
			input logic done, input logic [BP_PC_W-1:0] br_pc, input logic cond,
			input logic taken, input logic [BP_PC_W-1:0] target);
		@(negedge clk);
		if2bp_pc_i        = lk_pc;
		if2bp_pc_vld_i    = lk_vld;
		fu2bp_br_done_i   = done;		// Held for exactly one rising edge.
		fu2bp_br_pc_i     = br_pc;
		fu2bp_br_cond_i   = cond;
		fu2bp_br_taken_i  = taken;
		fu2bp_br_target_i = target;
	endtask

	// Resolution with a same-cycle lookup of the branch PC.
	task automatic resolve(input logic [BP_PC_W-1:0] pc, input logic cond,
			input logic taken, input logic [BP_PC_W-1:0] target);
		drive_cycle(pc, 1'b1, 1'b1, pc, cond, taken, target);
	endtask

	task automatic check_lookup(input logic [BP_PC_W-1:0] pc, input logic vld,
			input logic want_pred, input logic [BP_PC_W-1:0] want_target);
		drive_cycle(pc, vld, 1'b0, '0, 1'b0, 1'b0, '0);
		#(CLK_PERIOD/4);				// Mid low phase.
		assert (bp_pred_o === want_pred)
			else fail_now($sformatf("error: bp_pred_o expected %h actual %h",
				want_pred, bp_pred_o));
		assert (btb_target_o === want_target)
			else fail_now($sformatf("error: btb_target_o expected %h actual %h",
				want_target, btb_target_o));
	endtask

	function automatic logic [BP_PC_W-1:0] random_pc();
		logic [BP_PC_W-1:0] v;
		v      = {$urandom, $urandom};
		v[1:0] = 2'b00;					// Word aligned.
		return v;
	endfunction

	initial begin : watchdog
		int cycles;
		for (cycles = 0; cycles < MAX_CYCLES && !run_done; cycles++) begin
			@(posedge clk);
		end
		if (!run_done) begin
			$display("timeout: stimulus did not finish within %0d cycles", MAX_CYCLES);
			$display("tests failed");
			$fatal(1);
		end
	end

	initial begin : stimulus
		logic [BP_PC_W-1:0] pc_a;
		logic [BP_PC_W-1:0] pc_c;
		logic [BP_PC_W-1:0] pc_d;
		logic [BP_PC_W-1:0] pc_e;
		logic [BP_PC_W-1:0] tgt;
		logic [BP_PC_W-1:0] tgt2;
		logic [BP_PC_W-1:0] mix_pc [0:7];
		logic [BTB_TAG_W-1:0] tag;
		logic [BTB_IDX_W-1:0] idx;
		void'($urandom(SEED));
		error_cnt         = 0;
		rst_n_i           = 1'b0;
		if2bp_pc_i        = '0;
		if2bp_pc_vld_i    = 1'b0;
		fu2bp_br_done_i   = 1'b0;
		fu2bp_br_pc_i     = '0;
		fu2bp_br_cond_i   = 1'b0;
		fu2bp_br_taken_i  = 1'b0;
		fu2bp_br_target_i = '0;
		repeat (5) @(negedge clk);		// Five rising edges in reset.
		rst_n_i = 1'b1;

		for (int k = 0; k < 20; k++) begin
			check_lookup(random_pc(), 1'b1, 1'b0, '0);	// Empty tables.
		end

		pc_a = random_pc();
		tgt  = random_pc();
		resolve(pc_a, 1'b0, 1'b1, tgt);					// Unconditional taken.
		check_lookup(pc_a, 1'b1, 1'b1, tgt);
		check_lookup(pc_a, 1'b0, 1'b0, tgt);			// Fetch not valid.

		resolve(pc_a, 1'b0, 1'b0, random_pc());			// Evict.
		check_lookup(pc_a, 1'b1, 1'b0, '0);
		resolve(pc_a, 1'b0, 1'b1, tgt);
		resolve(pc_a ^ (64'h1 << 20), 1'b0, 1'b0, '0);	// Same row, other tag.
		check_lookup(pc_a, 1'b1, 1'b1, tgt);

		pc_c = random_pc();
		tgt  = random_pc();
		tgt2 = random_pc();
		resolve(pc_c, 1'b0, 1'b1, tgt);
		check_lookup(pc_c ^ (64'h1 << 40), 1'b1, 1'b0, '0);	// Alias misses.
		resolve(pc_c ^ (64'h1 << 40), 1'b0, 1'b1, tgt2);	// Alias replaces.
		check_lookup(pc_c ^ (64'h1 << 40), 1'b1, 1'b1, tgt2);
		check_lookup(pc_c, 1'b1, 1'b0, '0);

		pc_d = random_pc();
		pc_e = pc_d ^ (64'h1 << 7);						// Other BTB row, same weights.
		tgt  = random_pc();
		resolve(pc_e, 1'b1, 1'b1, tgt);					// Conditional entry that stays.
		for (int k = 0; k < 40; k++) begin
			resolve(pc_d, 1'b1, 1'b1, tgt);
		end
		check_lookup(pc_d, 1'b1, 1'b1, tgt);			// Trained toward taken.
		for (int k = 0; k < 40; k++) begin
			drive_cycle(pc_e, 1'b1, 1'b1, pc_d, 1'b1, 1'b0, tgt);	// Row seen via pc_e.
		end
		check_lookup(pc_e, 1'b1, 1'b0, tgt);			// Trained toward not taken.

		idx = BTB_IDX_W'($urandom);
		for (int i = 0; i < 8; i++) begin
			tag      = {$urandom, $urandom};
			tag[2:0] = 3'(i);							// Distinct tags.
			mix_pc[i] = {tag, idx, 2'b00};
		end
		for (int k = 0; k < 400; k++) begin
			resolve(mix_pc[$urandom % 8], 1'($urandom), 1'($urandom), random_pc());
			drive_cycle(mix_pc[$urandom % 8], 1'($urandom), 1'b0, '0, 1'b0, 1'b0, '0);
		end

		drive_cycle('0, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
		@(negedge clk);
		run_done = 1'b1;
		if (error_cnt == 0 && perceptron_bp_i.perceptron_bp_sva_i.fail_cnt == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* verification/perceptron_bp_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module perceptron_bp_sva import bp_pkg::*; (
	input logic               clk,
	input logic               rst_n_i,
	input logic               pc_vld_i,		// Fetch PC valid.
	input logic               pred_i,		// Taken prediction.
	input logic [BP_PC_W-1:0] target_i		// Predicted target.
);

	int unsigned fail_cnt = 0;		// Failed assertion count.

	// A fetch that is not valid is never predicted taken.
	property no_pred_without_vld;
		@(posedge clk) disable iff (!rst_n_i)
			!pc_vld_i |-> !pred_i;
	endproperty

	// Outputs are always driven once out of reset.
	property pred_known;
		@(posedge clk) disable iff (!rst_n_i)
			!$isunknown(pred_i);
	endproperty

	property target_known;
		@(posedge clk) disable iff (!rst_n_i)
			!$isunknown(target_i);
	endproperty

	// Cleared tables give an empty lookup on the edge after reset.
	property empty_after_reset;
		@(posedge clk)
			!rst_n_i |=> (!pred_i && (target_i == '0));
	endproperty

	no_pred_without_vld_a: assert property (no_pred_without_vld)
		else begin
			fail_cnt++;
			$error("prediction high while the fetch PC is not valid");
		end
	pred_known_a: assert property (pred_known)
		else begin
			fail_cnt++;
			$error("prediction carries an unknown value");
		end
	target_known_a: assert property (target_known)
		else begin
			fail_cnt++;
			$error("target carries an unknown value");
		end
	empty_after_reset_a: assert property (empty_after_reset)
		else begin
			fail_cnt++;
			$error("lookup not empty right after reset");
		end

endmodule

bind perceptron_bp perceptron_bp_sva perceptron_bp_sva_i (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.pc_vld_i (if2bp_pc_vld_i),
	.pred_i   (bp_pred_o),
	.target_i (btb_target_o)
);

`default_nettype wire

/* src/perceptron_bp.sv */
`timescale 1ns/10ps
`default_nettype none

module perceptron_bp import bp_pkg::*; (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic [BP_PC_W-1:0] if2bp_pc_i,			// Fetch PC.
	input  logic               if2bp_pc_vld_i,		// Fetch PC valid.
	input  logic               fu2bp_br_cond_i,		// Resolved branch is conditional.
	input  logic               fu2bp_br_taken_i,	// Resolved outcome.
	input  logic [BP_PC_W-1:0] fu2bp_br_pc_i,		// Resolved branch PC.
	input  logic [BP_PC_W-1:0] fu2bp_br_target_i,	// Resolved target.
	input  logic               fu2bp_br_done_i,		// Resolution strobe.

	output logic [BP_PC_W-1:0] btb_target_o,		// Predicted target.
	output logic               bp_pred_o			// Predicted taken.
);

	logic               btb_hit;		// Fetch PC found in the BTB.
	logic               btb_cond;		// Entry is conditional.
	logic [BP_PC_W-1:0] btb_target;		// Stored target.
	logic               pt_pred;		// Direction from the perceptron.

	perceptron perceptron_i (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.if2pt_pc_i       (if2bp_pc_i),
		.fu2pt_br_done_i  (fu2bp_br_done_i),
		.fu2pt_br_cond_i  (fu2bp_br_cond_i),
		.fu2pt_br_taken_i (fu2bp_br_taken_i),
		.fu2pt_br_pc_i    (fu2bp_br_pc_i),
		.pt_pred_o        (pt_pred)
	);

	btb btb_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.if_pc_i        (if2bp_pc_i),
		.ex_is_br_i     (fu2bp_br_done_i),
		.ex_is_cond_i   (fu2bp_br_cond_i),
		.ex_is_taken_i  (fu2bp_br_taken_i),
		.ex_pc_i        (fu2bp_br_pc_i),
		.ex_br_target_i (fu2bp_br_target_i),
		.is_hit_o       (btb_hit),
		.is_cond_o      (btb_cond),
		.btb_target_o   (btb_target)
	);

	assign btb_target_o = btb_target;

	// A miss is never predicted taken. Unconditional hits always are.
	always_comb begin
		if (if2bp_pc_vld_i && btb_hit) begin
			bp_pred_o = btb_cond ? pt_pred : 1'b1;	// Direction only matters for cond.
		end else begin
			bp_pred_o = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* perceptron/perceptron.sv */
`timescale 1ns/10ps
`default_nettype none

module perceptron import bp_pkg::*; (
	input  logic               clk,
	input  logic               rst_n_i,

	// Fetch lookup.
	input  logic [BP_PC_W-1:0] if2pt_pc_i,			// Fetch PC.

	// Branch resolution.
	input  logic               fu2pt_br_done_i,		// Resolved branch strobe.
	input  logic               fu2pt_br_cond_i,		// Branch is conditional.
	input  logic               fu2pt_br_taken_i,	// Branch outcome.
	input  logic [BP_PC_W-1:0] fu2pt_br_pc_i,		// Branch PC.

	output logic               pt_pred_o			// Predicted taken.
);

	logic [PT_HIST_LEN-1:0] ghr;		// Global history, bit 0 is the newest outcome.

	logic [PT_IDX_W-1:0] pred_idx;		// Row for fetch.
	logic [PT_IDX_W-1:0] train_idx;		// Row for the resolved branch.

	pt_weights_t pred_row;		// Weights for fetch.
	pt_weights_t train_row;		// Weights for the resolved branch.
	pt_weights_t new_row;		// Trained weights.

	logic signed [PT_SUM_W-1:0] pred_sum;	// Fetch dot product.
	logic signed [PT_SUM_W-1:0] train_sum;	// Training dot product.

	logic cond_done;	// Conditional branch resolved this cycle.
	logic mispred;		// Sign of train_sum disagrees with the outcome.
	logic low_conf;		// |train_sum| within the threshold.
	logic train_en;		// Write the trained row.

	// Bias plus each weight, added when its history bit is 1, else subtracted.
	function automatic logic signed [PT_SUM_W-1:0] dot(
		input pt_weights_t            row,
		input logic [PT_HIST_LEN-1:0] hist
	);
		logic signed [PT_SUM_W-1:0] acc;
		pt_weight_t w;
		w   = row[0];
		acc = w;				// Sign extended bias.
		for (int i = 0; i < PT_HIST_LEN; i++) begin
			w = row[i+1];
			if (hist[i]) begin
				acc = acc + w;
			end else begin
				acc = acc - w;
			end
		end
		return acc;
	endfunction

	// One step up or down, held at the limits.
	function automatic pt_weight_t sat_step(input pt_weight_t w, input logic up);
		pt_weight_t res;
		res = w;
		if (up && (int'(w) < PT_WEIGHT_MAX)) begin
			res = w + pt_weight_t'(1);
		end else if (!up && (int'(w) > PT_WEIGHT_MIN)) begin
			res = w - pt_weight_t'(1);
		end
		return res;
	endfunction

	assign pred_idx  = if2pt_pc_i[PT_IDX_W+1:2];
	assign train_idx = fu2pt_br_pc_i[PT_IDX_W+1:2];

	assign pred_sum  = dot(pred_row, ghr);
	assign train_sum = dot(train_row, ghr);		// Same history the branch was predicted with.

	assign pt_pred_o = ~pred_sum[PT_SUM_W-1];		// Taken when sum >= 0.

	assign cond_done = fu2pt_br_done_i && fu2pt_br_cond_i;
	assign mispred   = (~train_sum[PT_SUM_W-1]) != fu2pt_br_taken_i;
	assign low_conf  = (train_sum <= PT_THETA) && (train_sum >= -PT_THETA);
	assign train_en  = cond_done && (mispred || low_conf);

	// Move every weight toward agreement with the outcome.
	always_comb begin
		new_row[0] = sat_step(train_row[0], fu2pt_br_taken_i);	// Bias follows the outcome.
		for (int i = 0; i < PT_HIST_LEN; i++) begin
			new_row[i+1] = sat_step(train_row[i+1], fu2pt_br_taken_i == ghr[i]);
		end
	end

	// Prediction copy of the weights.
	bp_table #(
		.entry_t (pt_weights_t),
		.IDX_W   ($clog2(PT_ROWS))
	) pred_tbl_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rd_idx_i  (pred_idx),
		.rd_data_o (pred_row),
		.wr_en_i   (train_en),
		.wr_idx_i  (train_idx),
		.wr_data_i (new_row)
	);

	// Training copy, kept identical by the shared write.
	bp_table #(
		.entry_t (pt_weights_t),
		.IDX_W   ($clog2(PT_ROWS))
	) train_tbl_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rd_idx_i  (train_idx),
		.rd_data_o (train_row),
		.wr_en_i   (train_en),
		.wr_idx_i  (train_idx),
		.wr_data_i (new_row)
	);

	// Shift the outcome in after training uses the old history.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ghr <= '0;
		end else if (cond_done) begin
			ghr <= {ghr[PT_HIST_LEN-2:0], fu2pt_br_taken_i};
		end
	end

endmodule

`default_nettype wire

/* btb/btb.sv */
`timescale 1ns/10ps
`default_nettype none

module btb import bp_pkg::*; (
	input  logic               clk,
	input  logic               rst_n_i,

	// Fetch lookup.
	input  logic [BP_PC_W-1:0] if_pc_i,			// Fetch PC.

	// Branch resolution.
	input  logic               ex_is_br_i,		// Resolved branch strobe.
	input  logic               ex_is_cond_i,	// Branch is conditional.
	input  logic               ex_is_taken_i,	// Branch outcome.
	input  logic [BP_PC_W-1:0] ex_pc_i,			// Branch PC.
	input  logic [BP_PC_W-1:0] ex_br_target_i,	// Resolved target.

	// Lookup result.
	output logic               is_hit_o,		// Fetch PC is a known taken branch.
	output logic               is_cond_o,		// Stored entry is conditional.
	output logic [BP_PC_W-1:0] btb_target_o	// Predicted target, 0 on a miss.
);

	logic [BTB_IDX_W-1:0] if_idx;		// Lookup row.
	logic [BTB_TAG_W-1:0] if_tag;		// Lookup tag.
	logic [BTB_IDX_W-1:0] ex_idx;		// Resolution row.
	logic [BTB_TAG_W-1:0] ex_tag;		// Resolution tag.

	btb_entry_t if_entry;		// Row seen by fetch.
	btb_entry_t ex_entry;		// Row seen by the eviction check.
	btb_entry_t wr_entry;		// Row to be written.

	logic if_hit;		// Lookup hit.
	logic ex_match;		// Resolved PC owns its row.
	logic wr_en;		// Table write strobe.

	// Split both PCs into index and tag.
	assign if_idx = if_pc_i[BTB_IDX_W+1:2];
	assign if_tag = if_pc_i[BP_PC_W-1:BTB_IDX_W+2];
	assign ex_idx = ex_pc_i[BTB_IDX_W+1:2];
	assign ex_tag = ex_pc_i[BP_PC_W-1:BTB_IDX_W+2];

	// Eviction only applies when the stored branch is the resolved one.
	assign ex_match = ex_entry.valid && (ex_entry.tag == ex_tag);

	// Taken always writes. Not taken writes only to evict its own entry.
	assign wr_en = ex_is_br_i && (ex_is_taken_i || ex_match);

	always_comb begin
		wr_entry = '0;					// Not taken leaves an empty row.
		if (ex_is_taken_i) begin
			wr_entry.valid  = 1'b1;			// Allocate or refresh.
			wr_entry.tag    = ex_tag;
			wr_entry.cond   = ex_is_cond_i;
			wr_entry.target = ex_br_target_i;	// Latest target wins.
		end
	end

	// Fetch copy of the table.
	bp_table #(
		.entry_t (btb_entry_t),
		.IDX_W   ($clog2(BTB_ENTRIES))
	) lookup_tbl_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rd_idx_i  (if_idx),
		.rd_data_o (if_entry),
		.wr_en_i   (wr_en),
		.wr_idx_i  (ex_idx),
		.wr_data_i (wr_entry)
	);

	// Second copy with identical writes, read at the resolved PC.
	bp_table #(
		.entry_t (btb_entry_t),
		.IDX_W   ($clog2(BTB_ENTRIES))
	) check_tbl_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.rd_idx_i  (ex_idx),
		.rd_data_o (ex_entry),
		.wr_en_i   (wr_en),
		.wr_idx_i  (ex_idx),
		.wr_data_i (wr_entry)
	);

	assign if_hit = if_entry.valid && (if_entry.tag == if_tag);	// Valid and tag equal.

	assign is_hit_o     = if_hit;
	assign is_cond_o    = if_entry.cond;
	assign btb_target_o = if_hit ? if_entry.target : '0;		// No stale targets on a miss.

endmodule

`default_nettype wire

/* src/bp_table.sv */
`timescale 1ns/10ps
`default_nettype none

module bp_table #(
	parameter type entry_t = logic,	// Payload held in each row.
	parameter int  IDX_W   = 1		// Row index width.
) (
	input  logic             clk,
	input  logic             rst_n_i,

	input  logic [IDX_W-1:0] rd_idx_i,	// Combinational read address.
	output entry_t           rd_data_o,	// Row at rd_idx_i.

	input  logic             wr_en_i,	// Write strobe.
	input  logic [IDX_W-1:0] wr_idx_i,	// Write address.
	input  entry_t           wr_data_i	// Write payload.
);

	entry_t mem [0:(1 << IDX_W)-1];	// Row storage.

	// All rows start cleared, so every entry powers up empty.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < (1 << IDX_W); i++) begin
				mem[i] <= '0;		// Clear row.
			end
		end else if (wr_en_i) begin
			mem[wr_idx_i] <= wr_data_i;	// Update one row.
		end
	end

	// Reads see the state before this cycle's write.
	assign rd_data_o = mem[rd_idx_i];

endmodule

`default_nettype wire

/* common/bp_pkg.sv */
`default_nettype none

package bp_pkg;

	// Program counter width.
	localparam int BP_PC_W = 64;

	// BTB geometry. Instructions are word aligned, so PC[1:0] is ignored.
	localparam int BTB_IDX_W   = 6;					// Index bits, taken from PC[7:2].
	localparam int BTB_ENTRIES = 1 << BTB_IDX_W;	// Direct mapped rows.
	localparam int BTB_TAG_W   = BP_PC_W - BTB_IDX_W - 2;	// Remaining upper PC bits.

	// One BTB row.
	typedef struct packed {
		logic                 valid;	// Entry holds a live branch.
		logic [BTB_TAG_W-1:0] tag;		// Upper PC bits of the branch.
		logic                 cond;		// Conditional branch flag.
		logic [BP_PC_W-1:0]   target;	// Last taken target.
	} btb_entry_t;

	// Perceptron geometry.
	localparam int PT_IDX_W    = 5;					// Row index, taken from PC[6:2].
	localparam int PT_ROWS     = 1 << PT_IDX_W;	// Weight rows.
	localparam int PT_HIST_LEN = 16;				// Global history bits.

	// Signed weights, saturating at the two's complement limits.
	localparam int PT_WEIGHT_W   = 8;
	localparam int PT_WEIGHT_MAX = (1 << (PT_WEIGHT_W - 1)) - 1;	// +127.
	localparam int PT_WEIGHT_MIN = -(1 << (PT_WEIGHT_W - 1));		// -128.

	// Dot product width, enough for 17 weights at full magnitude.
	localparam int PT_SUM_W = 14;

	// Training threshold, floor(1.93 * 16 + 14).
	localparam int PT_THETA = 44;

	typedef logic signed [PT_WEIGHT_W-1:0] pt_weight_t;	// One weight.

	// Index 0 is the bias, index i+1 pairs with history bit i.
	typedef pt_weight_t [PT_HIST_LEN:0] pt_weights_t;

endpackage

`default_nettype wire
